/* Bender.yml */
package:
  name: mips_alu_pipe

export_include_dirs:
  - verilog

sources:
  - verilog/mips_pkg.sv
  - verilog/control_unit.sv
  - verilog/reg_file.sv
  - verilog/id_ex.sv
  - verilog/alu.sv
  - verilog/exec_stage.sv
  - verilog/mips_alu_pipe.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/mips_alu_pipe_tb.sv

/* dv/mips_alu_pipe_tb.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module mips_alu_pipe_tb import mips_pkg::*; ();

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    logic [31:0]             in_instr;
    logic                    in_ready;
    logic                    res_valid;
    logic [`MIPS_REG_W-1:0]  res_reg;
    logic [`MIPS_DATA_W-1:0] res_data;
    logic                    res_ready;

    // instruction table
    string       tbl_name[$];
    logic [31:0] tbl_word[$];
    bit          tbl_legal[$];
    int          tbl_dest[$];
    logic [31:0] tbl_value[$];

    int          num_legal = 0;
    int          checked = 0;
    int          chk_idx = 0;
    bit          table_built = 0;
    logic [31:0] rand_state = 32'h7de7dd29;

    bit                      held = 0;  // a result was waiting at the last sample
    logic [`MIPS_REG_W-1:0]  held_reg;
    logic [`MIPS_DATA_W-1:0] held_data;

    mips_alu_pipe DUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .res_valid (res_valid),
        .res_reg   (res_reg),
        .res_data  (res_data),
        .res_ready (res_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rtype_word(funct_t fn, int rs, int rt, int rd, int sh);
        return {op_rtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] itype_word(opcode_t op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_entry(string name, logic [31:0] word, bit legal, int dest,
                             logic [31:0] value);
        tbl_name.push_back(name);
        tbl_word.push_back(word);
        tbl_legal.push_back(legal);
        tbl_dest.push_back(dest);
        tbl_value.push_back(value);
        if (legal)
            num_legal++;
    endtask

    task automatic report_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic build_table();
        // immediates
        add_entry("addi_neg", itype_word(op_addi, 0, 1, 16'hfffb), 1, 1, 32'hfffffffb);
        add_entry("ori_zext", itype_word(op_ori, 0, 2, 16'h8001), 1, 2, 32'h00008001);
        add_entry("lui", itype_word(op_lui, 0, 3, 16'h1234), 1, 3, 32'h12340000);
        add_entry("addi_pos", itype_word(op_addi, 0, 4, 16'h0007), 1, 4, 32'h00000007);
        // r-type set
        add_entry("add", rtype_word(fn_add, 3, 2, 5, 0), 1, 5, 32'h12348001);
        add_entry("sub", rtype_word(fn_sub, 4, 1, 6, 0), 1, 6, 32'h0000000c);
        add_entry("and", rtype_word(fn_and, 5, 3, 7, 0), 1, 7, 32'h12340000);
        add_entry("or", rtype_word(fn_or, 2, 4, 8, 0), 1, 8, 32'h00008007);
        add_entry("slt_true", rtype_word(fn_slt, 1, 4, 9, 0), 1, 9, 32'h00000001);
        add_entry("slt_false", rtype_word(fn_slt, 4, 1, 10, 0), 1, 10, 32'h00000000);
        add_entry("sll", rtype_word(fn_sll, 0, 2, 11, 4), 1, 11, 32'h00080010);
        add_entry("srl", rtype_word(fn_srl, 0, 1, 12, 28), 1, 12, 32'h0000000f);
        // forwarding chains
        add_entry("fwd_base", itype_word(op_addi, 0, 13, 16'd100), 1, 13, 32'h00000064);
        add_entry("fwd_rs", rtype_word(fn_add, 13, 4, 14, 0), 1, 14, 32'h0000006b);
        add_entry("fwd_rt", rtype_word(fn_sub, 4, 14, 15, 0), 1, 15, 32'hffffff9c);
        add_entry("fwd_both", rtype_word(fn_add, 15, 15, 16, 0), 1, 16, 32'hffffff38);
        add_entry("bypass_two", rtype_word(fn_or, 15, 0, 17, 0), 1, 17, 32'hffffff9c);
        add_entry("fwd_shift", rtype_word(fn_sll, 0, 17, 18, 1), 1, 18, 32'hffffff38);
        // r0 writes are reported but never stick
        add_entry("write_r0", itype_word(op_addi, 0, 0, 16'h0055), 1, 0, 32'h00000055);
        add_entry("read_r0_next", rtype_word(fn_add, 0, 4, 19, 0), 1, 19, 32'h00000007);
        add_entry("read_r0_two", rtype_word(fn_or, 0, 0, 20, 0), 1, 20, 32'h00000000);
        // unsupported encodings in the middle of a chain
        add_entry("bad_opcode", {6'h23, 5'd1, 5'd2, 16'h0000}, 0, 0, 32'h0);
        add_entry("after_bad_op", itype_word(op_addi, 20, 21, 16'h0010), 1, 21, 32'h00000010);
        add_entry("bad_funct", {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h27}, 0, 0, 32'h0);
        add_entry("after_bad_fn", rtype_word(fn_add, 21, 21, 22, 0), 1, 22, 32'h00000020);
        add_entry("addi_dec", itype_word(op_addi, 22, 23, 16'hffff), 1, 23, 32'h0000001f);
        add_entry("lui_ones", itype_word(op_lui, 0, 24, 16'hffff), 1, 24, 32'hffff0000);
        add_entry("ori_fwd", itype_word(op_ori, 24, 25, 16'hffff), 1, 25, 32'hffffffff);
        table_built = 1;
    endtask

    // main sequence applies one entry per accepted instruction
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        res_ready = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < tbl_word.size(); i++) begin
            in_valid <= 1'b1;
            in_instr <= tbl_word[i];
            @(negedge clk);
            while (!in_ready)
                @(negedge clk);  // hold until the pipeline moves
            @(posedge clk);
        end
        in_valid <= 1'b0;
        in_instr <= '0;
        wait (checked == num_legal);
        repeat (5) @(posedge clk);  // room for a stray extra result
        @(negedge clk);
        assert (!res_valid) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("an extra result is waiting after the last instruction retired");
            report_failure();
        end
    end

    // random back-pressure on the result port
    initial begin
        wait (!reset);
        forever begin
            @(posedge clk);
            rand_state = lcg_next(rand_state);
            res_ready <= rand_state[31:30] != 2'b00;
        end
    end

    // outputs are sampled mid-cycle and a retire completes on the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (in_ready == !(res_valid && !res_ready)) else begin
                $display("** Error [stall]: in_ready expected %b actual %b",
                         !(res_valid && !res_ready), in_ready);
                report_failure();
            end
            if (held) begin
                assert (res_valid && res_reg == held_reg && res_data == held_data) else begin
                    $display("waiting result was dropped or changed before it retired");
                    report_failure();
                end
            end
            held      = res_valid && !res_ready;
            held_reg  = res_reg;
            held_data = res_data;
            if (res_valid && res_ready) begin
                while (chk_idx < tbl_word.size() && !tbl_legal[chk_idx])
                    chk_idx++;  // bubbles retire nothing
                assert (chk_idx < tbl_word.size()) else begin
                    $display("a result retired after every instruction had completed");
                    report_failure();
                end
                assert (res_reg == tbl_dest[chk_idx]) else begin
                    $display("** Error [%s]: res_reg expected %0d actual %0d",
                             tbl_name[chk_idx], tbl_dest[chk_idx], res_reg);
                    report_failure();
                end
                assert (res_data == tbl_value[chk_idx]) else begin
                    $display("** Error [%s]: res_data expected %h actual %h",
                             tbl_name[chk_idx], tbl_value[chk_idx], res_data);
                    report_failure();
                end
                chk_idx++;
                checked++;
            end
        end
    end

    // watchdog sized from the table
    initial begin
        wait (table_built);
        repeat (5 + 40 * tbl_word.size()) @(posedge clk);
        $display("timeout: results stopped arriving, %0d of %0d retired", checked, num_legal);
        report_failure();
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/id_ex.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/mips_alu_pipe.sv
dv/mips_alu_pipe_tb.sv

/* verilog/alu.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module alu import mips_pkg::*; (
    input  alu_op_t                op,
    input  logic [`MIPS_DATA_W-1:0] a,      // rs
    input  logic [`MIPS_DATA_W-1:0] b,      // rt or immediate
    input  logic [4:0]             shamt,
    output logic [`MIPS_DATA_W-1:0] y
);

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_slt: y = {{(`MIPS_DATA_W-1){1'b0}}, lt};
            alu_sll: y = b << shamt;  // shifts act on rt
            alu_srl: y = b >> shamt;
            alu_lui: y = b << 16;     // imm into the upper half
            default: y = '0;
        endcase
    end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ns
module control_unit import mips_pkg::*; (
    input  opcode_t opcode,
    input  funct_t  funct,
    output logic    legal,     // supported encoding
    output logic    alusrc,    // 1 = immediate as second operand
    output logic    regdst,    // 1 = rd, 0 = rt
    output logic    regwrite,
    output logic    zero_ext,  // 1 = zero extend the immediate
    output alu_op_t aluop
);

    always_comb begin
        legal    = 1'b0;
        alusrc   = 1'b0;
        regdst   = 1'b0;
        regwrite = 1'b0;
        zero_ext = 1'b0;
        aluop    = alu_add;

        case (opcode)
            op_rtype: begin
                regdst   = 1'b1;
                legal    = 1'b1;
                regwrite = 1'b1;
                case (funct)
                    fn_add:  aluop = alu_add;
                    fn_sub:  aluop = alu_sub;
                    fn_and:  aluop = alu_and;
                    fn_or:   aluop = alu_or;
                    fn_slt:  aluop = alu_slt;
                    fn_sll:  aluop = alu_sll;
                    fn_srl:  aluop = alu_srl;
                    default: begin
                        // unknown funct becomes a bubble
                        legal    = 1'b0;
                        regwrite = 1'b0;
                    end
                endcase
            end
            op_addi: begin
                legal    = 1'b1;
                alusrc   = 1'b1;
                regwrite = 1'b1;
                aluop    = alu_add;  // sign extended imm
            end
            op_ori: begin
                legal    = 1'b1;
                alusrc   = 1'b1;
                regwrite = 1'b1;
                zero_ext = 1'b1;
                aluop    = alu_or;
            end
            op_lui: begin
                legal    = 1'b1;
                alusrc   = 1'b1;
                regwrite = 1'b1;
                zero_ext = 1'b1;
                aluop    = alu_lui;
            end
            default: begin
                // everything else, loads, stores, branches, stays illegal
                legal = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module exec_stage import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    // from id_ex
    input  logic                   valid,
    input  logic [`MIPS_DATA_W-1:0] reg_data1,
    input  logic [`MIPS_DATA_W-1:0] reg_data2,
    input  logic [`MIPS_DATA_W-1:0] imm,
    input  logic [`MIPS_REG_W-1:0]  rs,
    input  logic [`MIPS_REG_W-1:0]  rt,
    input  logic [`MIPS_REG_W-1:0]  dest,
    input  logic [4:0]             shamt,
    input  logic                   alusrc,
    input  logic                   regwrite,
    input  alu_op_t                aluop,

    output logic                   res_valid,
    output logic [`MIPS_REG_W-1:0]  res_reg,
    output logic [`MIPS_DATA_W-1:0] res_data
);

    logic                    fwd_a;
    logic                    fwd_b;
    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] op_rt;
    logic [`MIPS_DATA_W-1:0] op_b;
    logic [`MIPS_DATA_W-1:0] alu_y;

    // the waiting result is newer than anything read from the register file
    assign fwd_a = res_valid && res_reg != '0 && res_reg == rs;
    assign fwd_b = res_valid && res_reg != '0 && res_reg == rt;

    assign op_a  = fwd_a ? res_data : reg_data1;
    assign op_rt = fwd_b ? res_data : reg_data2;
    assign op_b  = alusrc ? imm : op_rt;

    alu u_alu (
        .op    (aluop),
        .a     (op_a),
        .b     (op_b),
        .shamt (shamt),
        .y     (alu_y)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_reg   <= '0;
            res_data  <= '0;
        end else if (!stall) begin
            res_valid <= valid & regwrite;
            res_reg   <= dest;  // destination travels with the result
            res_data  <= alu_y;
        end
    end

endmodule

/* verilog/id_ex.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module id_ex import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,      // hold everything
    input  logic                   valid_in,   // accepted and legal

    input  logic [`MIPS_DATA_W-1:0] reg_data1,
    input  logic [`MIPS_DATA_W-1:0] reg_data2,
    input  logic [`MIPS_DATA_W-1:0] imm,       // already extended
    input  logic [`MIPS_REG_W-1:0]  rs,
    input  logic [`MIPS_REG_W-1:0]  rt,
    input  logic [`MIPS_REG_W-1:0]  dest,      // rd or rt, picked by regdst
    input  logic [4:0]             shamt,
    input  logic                   alusrc_in,
    input  logic                   regwrite_in,
    input  alu_op_t                aluop_in,

    output logic                   valid_out,
    output logic [`MIPS_DATA_W-1:0] reg_data1_out,
    output logic [`MIPS_DATA_W-1:0] reg_data2_out,
    output logic [`MIPS_DATA_W-1:0] imm_out,
    output logic [`MIPS_REG_W-1:0]  rs_out,
    output logic [`MIPS_REG_W-1:0]  rt_out,
    output logic [`MIPS_REG_W-1:0]  dest_out,
    output logic [4:0]             shamt_out,
    output logic                   alusrc_out,
    output logic                   regwrite_out,
    output alu_op_t                aluop_out
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_out     <= 1'b0;
            reg_data1_out <= '0;
            reg_data2_out <= '0;
            imm_out       <= '0;
            rs_out        <= '0;
            rt_out        <= '0;
            dest_out      <= '0;
            shamt_out     <= '0;
            alusrc_out    <= 1'b0;
            regwrite_out  <= 1'b0;
            aluop_out     <= alu_add;
        end else if (!stall) begin
            valid_out     <= valid_in;
            reg_data1_out <= reg_data1;
            reg_data2_out <= reg_data2;
            imm_out       <= imm;
            rs_out        <= rs;   // for forwarding
            rt_out        <= rt;
            dest_out      <= dest;
            shamt_out     <= shamt;
            alusrc_out    <= alusrc_in;
            regwrite_out  <= valid_in & regwrite_in;  // bubble never writes
            aluop_out     <= aluop_in;
        end
    end

endmodule

/* verilog/mips_alu_pipe.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module mips_alu_pipe import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [31:0]            in_instr,
    output logic                   in_ready,
    output logic                   res_valid,
    output logic [`MIPS_REG_W-1:0]  res_reg,
    output logic [`MIPS_DATA_W-1:0] res_data,
    input  logic                   res_ready
);

    opcode_t                 opcode;
    funct_t                  funct;
    logic [`MIPS_REG_W-1:0]  rs;
    logic [`MIPS_REG_W-1:0]  rt;
    logic [`MIPS_REG_W-1:0]  rd;
    logic [`MIPS_REG_W-1:0]  dest;
    logic [4:0]              shamt;
    logic [15:0]             imm16;
    logic [`MIPS_DATA_W-1:0] imm;

    logic    legal;
    logic    alusrc;
    logic    regdst;
    logic    regwrite;
    logic    zero_ext;
    alu_op_t aluop;

    logic                    stall;
    logic                    retire;
    logic                    dec_valid;
    logic [`MIPS_DATA_W-1:0] rd_data1;
    logic [`MIPS_DATA_W-1:0] rd_data2;

    logic                    ex_valid;
    logic [`MIPS_DATA_W-1:0] ex_data1;
    logic [`MIPS_DATA_W-1:0] ex_data2;
    logic [`MIPS_DATA_W-1:0] ex_imm;
    logic [`MIPS_REG_W-1:0]  ex_rs;
    logic [`MIPS_REG_W-1:0]  ex_rt;
    logic [`MIPS_REG_W-1:0]  ex_dest;
    logic [4:0]              ex_shamt;
    logic                    ex_alusrc;
    logic                    ex_regwrite;
    alu_op_t                 ex_aluop;

    // instruction fields
    assign opcode = opcode_t'(in_instr[31:26]);
    assign rs     = in_instr[25:21];
    assign rt     = in_instr[20:16];
    assign rd     = in_instr[15:11];
    assign shamt  = in_instr[10:6];
    assign funct  = funct_t'(in_instr[5:0]);
    assign imm16  = in_instr[15:0];

    assign imm  = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign dest = regdst ? rd : rt;

    // a waiting result freezes both stages
    assign stall     = res_valid & ~res_ready;
    assign in_ready  = ~stall;
    assign retire    = res_valid & res_ready;
    assign dec_valid = in_valid & in_ready & legal;  // illegal ones drop out here

    control_unit u_ctrl (
        .opcode   (opcode),
        .funct    (funct),
        .legal    (legal),
        .alusrc   (alusrc),
        .regdst   (regdst),
        .regwrite (regwrite),
        .zero_ext (zero_ext),
        .aluop    (aluop)
    );

    reg_file u_rf (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (rs),
        .rd_addr2 (rt),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_en    (retire),    // write back on retire
        .wr_addr  (res_reg),
        .wr_data  (res_data)
    );

    id_ex u_id_ex (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .valid_in      (dec_valid),
        .reg_data1     (rd_data1),
        .reg_data2     (rd_data2),
        .imm           (imm),
        .rs            (rs),
        .rt            (rt),
        .dest          (dest),
        .shamt         (shamt),
        .alusrc_in     (alusrc),
        .regwrite_in   (regwrite),
        .aluop_in      (aluop),
        .valid_out     (ex_valid),
        .reg_data1_out (ex_data1),
        .reg_data2_out (ex_data2),
        .imm_out       (ex_imm),
        .rs_out        (ex_rs),
        .rt_out        (ex_rt),
        .dest_out      (ex_dest),
        .shamt_out     (ex_shamt),
        .alusrc_out    (ex_alusrc),
        .regwrite_out  (ex_regwrite),
        .aluop_out     (ex_aluop)
    );

    exec_stage u_exec (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .valid     (ex_valid),
        .reg_data1 (ex_data1),
        .reg_data2 (ex_data2),
        .imm       (ex_imm),
        .rs        (ex_rs),
        .rt        (ex_rt),
        .dest      (ex_dest),
        .shamt     (ex_shamt),
        .alusrc    (ex_alusrc),
        .regwrite  (ex_regwrite),
        .aluop     (ex_aluop),
        .res_valid (res_valid),
        .res_reg   (res_reg),
        .res_data  (res_data)
    );

endmodule

/* verilog/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and register file sizes, fixed by the instruction set
`define MIPS_DATA_W   32
`define MIPS_REG_W    5
`define MIPS_NUM_REGS 32

`endif

/* verilog/mips_pkg.sv */
package mips_pkg;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f
    } opcode_t;

    // r-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    // operations the execute stage understands
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_lui = 4'd7
    } alu_op_t;

endpackage

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`include "mips_consts.svh"
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MIPS_REG_W-1:0]  rd_addr1,
    input  logic [`MIPS_REG_W-1:0]  rd_addr2,
    output logic [`MIPS_DATA_W-1:0] rd_data1,
    output logic [`MIPS_DATA_W-1:0] rd_data2,
    input  logic                   wr_en,
    input  logic [`MIPS_REG_W-1:0]  wr_addr,
    input  logic [`MIPS_DATA_W-1:0] wr_data
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;  // r0 never written
        end
    end

    // r0 reads zero and a same-cycle write passes straight through
    assign rd_data1 = (rd_addr1 == '0) ? '0 :
                      (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 :
                      (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule
